// ==== common/dec_if.sv ====
// decoded control fields from the decoder to the operand and immediate logic
`timescale 1ns/1ps

interface dec_if import decode_pkg::*; ();

    op_t       op;
    alu_mode_t alu_mode;
    opa_sel_t  opa_sel;
    opb_sel_t  opb_sel;
    imm_kind_t imm_kind;
    logic      wen;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;

    modport drv (
        output op, alu_mode, opa_sel, opb_sel, imm_kind, wen, rd, rs1, rs2
    );

    modport dp (input opa_sel, opb_sel, rs1, rs2);

    modport imm (input imm_kind);

endinterface

// ==== common/decode_pkg.sv ====
// decode stage widths, RV opcodes, operation and select enums, decode control struct
package decode_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     inst_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;

    typedef enum logic [7:0] {
        op_none,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_or, op_and,
        op_addiw, op_slliw, op_srliw, op_sraiw,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw
    } op_t;

    // numeric values shared with the execute stage ALU
    typedef enum logic [7:0] {
        alu_add  = 8'd0,
        alu_sub  = 8'd1,
        alu_slt  = 8'd2,
        alu_sltu = 8'd3,
        alu_and  = 8'd4,
        alu_or   = 8'd6,
        alu_xor  = 8'd7,
        alu_sll  = 8'd8,
        alu_srl  = 8'd9,
        alu_sra  = 8'd10
    } alu_mode_t;

    typedef enum logic [2:0] {
        opa_src1,
        opa_src1_lo_zext,  // low word, zero-extended
        opa_src1_lo_high,  // low word moved to upper half
        opa_pc,
        opa_imm,
        opa_zero
    } opa_sel_t;

    typedef enum logic [2:0] {
        opb_src2,
        opb_src2_lo6,
        opb_src2_lo5,
        opb_imm,
        opb_zero
    } opb_sel_t;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j,
        imm_sh6,
        imm_sh5,
        imm_none
    } imm_kind_t;

    typedef struct packed {
        op_t       op;
        logic      wen;
        alu_mode_t alu_mode;
        opa_sel_t  opa_sel;
        opb_sel_t  opb_sel;
        imm_kind_t imm_kind;
    } dec_ctrl_t;

endpackage

// ==== decoder/imm_gen.sv ====
// immediate generator for the I, S, B, U, J and shift-amount forms
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
    input  inst_t inst_q,
    dec_if.imm    dec,
    output xlen_t imm
);

    logic sgn;

    assign sgn = inst_q[31];

    always_comb begin
        case (dec.imm_kind)
            imm_i:   imm = {{52{sgn}}, inst_q[31:20]};
            imm_s:   imm = {{52{sgn}}, inst_q[31:25], inst_q[11:7]};
            imm_b:   imm = {{51{sgn}}, inst_q[31], inst_q[7], inst_q[30:25],
                            inst_q[11:8], 1'b0};
            imm_u:   imm = {{32{sgn}}, inst_q[31:12], 12'b0};
            imm_j:   imm = {{43{sgn}}, inst_q[31], inst_q[19:12], inst_q[20],
                            inst_q[30:21], 1'b0};
            imm_sh6: imm = {58'b0, inst_q[25:20]};
            imm_sh5: imm = {59'b0, inst_q[24:20]};  // W shifts use 5 bits
            default: imm = '0;
        endcase
    end

endmodule

// ==== decoder/inst_decoder.sv ====
// RV64I instruction decoder: operation match and control field lookup
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
    input  logic  valid_q,
    input  inst_t inst_q,
    dec_if.drv    dec
);

    inst_t     inst_g;
    op_t       op;
    dec_ctrl_t ctrl;

    // control fields for each operation
    function automatic dec_ctrl_t ctrl_of(op_t o);
        dec_ctrl_t c;
        c.op       = o;
        c.wen      = 1'b1;
        c.alu_mode = alu_add;
        c.opa_sel  = opa_src1;
        c.opb_sel  = opb_src2;
        c.imm_kind = imm_none;
        case (o)
            op_lui: begin
                c.opa_sel  = opa_imm;
                c.opb_sel  = opb_zero;
                c.imm_kind = imm_u;
            end
            op_auipc: begin
                c.opa_sel  = opa_pc;
                c.opb_sel  = opb_imm;
                c.imm_kind = imm_u;
            end
            op_jal: begin
                c.opa_sel  = opa_pc;
                c.opb_sel  = opb_imm;
                c.imm_kind = imm_j;
            end
            op_jalr, op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
            op_addi, op_addiw: begin
                c.opb_sel  = opb_imm;
                c.imm_kind = imm_i;
            end
            op_slti, op_sltiu, op_xori, op_ori, op_andi: begin
                c.opb_sel  = opb_imm;
                c.imm_kind = imm_i;
                case (o)
                    op_slti:  c.alu_mode = alu_slt;
                    op_sltiu: c.alu_mode = alu_sltu;
                    op_xori:  c.alu_mode = alu_xor;
                    op_ori:   c.alu_mode = alu_or;
                    default:  c.alu_mode = alu_and;
                endcase
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                c.wen      = 1'b0;
                c.alu_mode = alu_sub;  // compare by subtraction
                c.imm_kind = imm_b;    // target add happens elsewhere
            end
            op_sb, op_sh, op_sw, op_sd: begin
                c.wen      = 1'b0;
                c.opb_sel  = opb_imm;
                c.imm_kind = imm_s;
            end
            op_slli, op_srli, op_srai: begin
                c.opb_sel  = opb_imm;
                c.imm_kind = imm_sh6;
                c.alu_mode = (o == op_slli) ? alu_sll :
                             (o == op_srli) ? alu_srl : alu_sra;
            end
            op_slliw, op_srliw: begin
                c.opa_sel  = opa_src1_lo_zext;
                c.opb_sel  = opb_imm;
                c.imm_kind = imm_sh5;
                c.alu_mode = (o == op_slliw) ? alu_sll : alu_srl;
            end
            op_sraiw: begin
                c.opa_sel  = opa_src1_lo_high;  // sign bit lands on bit 63
                c.opb_sel  = opb_imm;
                c.imm_kind = imm_sh5;
                c.alu_mode = alu_sra;
            end
            op_sub, op_subw: c.alu_mode = alu_sub;
            op_slt:          c.alu_mode = alu_slt;
            op_sltu:         c.alu_mode = alu_sltu;
            op_xor:          c.alu_mode = alu_xor;
            op_or:           c.alu_mode = alu_or;
            op_and:          c.alu_mode = alu_and;
            op_sll, op_srl: begin
                c.opb_sel  = opb_src2_lo6;
                c.alu_mode = (o == op_sll) ? alu_sll : alu_srl;
            end
            op_sllw: begin
                c.opb_sel  = opb_src2_lo5;
                c.alu_mode = alu_sll;
            end
            op_srlw, op_sraw: begin
                c.opa_sel  = opa_src1_lo_high;
                c.opb_sel  = opb_src2_lo5;
                c.alu_mode = (o == op_srlw) ? alu_srl : alu_sra;
            end
            op_add, op_addw: c.alu_mode = alu_add;
            default: begin  // op_none, empty slot or unknown encoding
                c.wen     = 1'b0;
                c.opa_sel = opa_zero;
                c.opb_sel = opb_zero;
            end
        endcase
        return c;
    endfunction

    assign inst_g = valid_q ? inst_q : '0;  // bubble decodes as op_none

    // {funct7, funct3, opcode}
    always_comb begin
        casez ({inst_g[31:25], inst_g[14:12], inst_g[6:0]})
            {7'b???????, 3'b???, opc_lui}:   op = op_lui;
            {7'b???????, 3'b???, opc_auipc}: op = op_auipc;
            {7'b???????, 3'b???, opc_jal}:   op = op_jal;
            {7'b???????, 3'b000, opc_jalr}:  op = op_jalr;
            {7'b???????, 3'b000, opc_branch}: op = op_beq;
            {7'b???????, 3'b001, opc_branch}: op = op_bne;
            {7'b???????, 3'b100, opc_branch}: op = op_blt;
            {7'b???????, 3'b101, opc_branch}: op = op_bge;
            {7'b???????, 3'b110, opc_branch}: op = op_bltu;
            {7'b???????, 3'b111, opc_branch}: op = op_bgeu;
            {7'b???????, 3'b000, opc_load}:  op = op_lb;
            {7'b???????, 3'b001, opc_load}:  op = op_lh;
            {7'b???????, 3'b010, opc_load}:  op = op_lw;
            {7'b???????, 3'b011, opc_load}:  op = op_ld;
            {7'b???????, 3'b100, opc_load}:  op = op_lbu;
            {7'b???????, 3'b101, opc_load}:  op = op_lhu;
            {7'b???????, 3'b110, opc_load}:  op = op_lwu;
            {7'b???????, 3'b000, opc_store}: op = op_sb;
            {7'b???????, 3'b001, opc_store}: op = op_sh;
            {7'b???????, 3'b010, opc_store}: op = op_sw;
            {7'b???????, 3'b011, opc_store}: op = op_sd;
            {7'b???????, 3'b000, opc_op_imm}: op = op_addi;
            {7'b???????, 3'b010, opc_op_imm}: op = op_slti;
            {7'b???????, 3'b011, opc_op_imm}: op = op_sltiu;
            {7'b???????, 3'b100, opc_op_imm}: op = op_xori;
            {7'b???????, 3'b110, opc_op_imm}: op = op_ori;
            {7'b???????, 3'b111, opc_op_imm}: op = op_andi;
            {7'b000000?, 3'b001, opc_op_imm}: op = op_slli;  // bit 25 is shamt[5]
            {7'b000000?, 3'b101, opc_op_imm}: op = op_srli;
            {7'b010000?, 3'b101, opc_op_imm}: op = op_srai;
            {7'b0000000, 3'b000, opc_op}:    op = op_add;
            {7'b0100000, 3'b000, opc_op}:    op = op_sub;
            {7'b0000000, 3'b001, opc_op}:    op = op_sll;
            {7'b0000000, 3'b010, opc_op}:    op = op_slt;
            {7'b0000000, 3'b011, opc_op}:    op = op_sltu;
            {7'b0000000, 3'b100, opc_op}:    op = op_xor;
            {7'b0000000, 3'b101, opc_op}:    op = op_srl;
            {7'b0000000, 3'b110, opc_op}:    op = op_or;
            {7'b0000000, 3'b111, opc_op}:    op = op_and;
            {7'b???????, 3'b000, opc_op_imm_32}: op = op_addiw;
            {7'b0000000, 3'b001, opc_op_imm_32}: op = op_slliw;
            {7'b0000000, 3'b101, opc_op_imm_32}: op = op_srliw;
            {7'b0100000, 3'b101, opc_op_imm_32}: op = op_sraiw;
            {7'b0000000, 3'b000, opc_op_32}: op = op_addw;
            {7'b0100000, 3'b000, opc_op_32}: op = op_subw;
            {7'b0000000, 3'b001, opc_op_32}: op = op_sllw;
            {7'b0000000, 3'b101, opc_op_32}: op = op_srlw;
            {7'b0100000, 3'b101, opc_op_32}: op = op_sraw;
            default:                         op = op_none;
        endcase
    end

    assign ctrl = ctrl_of(op);

    assign dec.op       = ctrl.op;
    assign dec.wen      = ctrl.wen;
    assign dec.alu_mode = ctrl.alu_mode;
    assign dec.opa_sel  = ctrl.opa_sel;
    assign dec.opb_sel  = ctrl.opb_sel;
    assign dec.imm_kind = ctrl.imm_kind;
    assign dec.rd       = inst_g[11:7];
    assign dec.rs1      = inst_g[19:15];
    assign dec.rs2      = inst_g[24:20];

endmodule

// ==== sim.f ====
common/decode_pkg.sv
common/dec_if.sv
src/if_id_reg.sv
decoder/inst_decoder.sv
decoder/imm_gen.sv
src/operand_mux.sv
src/decode_stage.sv
tb/decode_stage_props.sv
tb/tb_decode_stage.sv

// ==== src/decode_stage.sv ====
// instruction decode stage top: IF/ID register, decoder, immediate and operand logic
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  xlen_t     gpr [32],
    input  logic      valid_in,
    input  xlen_t     pc_in,
    input  inst_t     inst_in,
    output logic      valid_out,
    output xlen_t     pc_out,
    output inst_t     inst_out,
    output xlen_t     alu_a,
    output xlen_t     alu_b,
    output alu_mode_t alu_mode,
    output reg_idx_t  rd,
    output logic      wen,
    output op_t       op
);

    xlen_t imm;

    dec_if dec ();

    // registered slot drives the outputs and the decode logic
    if_id_reg u_if_id_reg (
        .clk      (clk),
        .rst      (rst),
        .valid_in (valid_in),
        .pc_in    (pc_in),
        .inst_in  (inst_in),
        .valid_q  (valid_out),
        .pc_q     (pc_out),
        .inst_q   (inst_out)
    );

    inst_decoder u_inst_decoder (
        .valid_q (valid_out),
        .inst_q  (inst_out),
        .dec     (dec.drv)
    );

    imm_gen u_imm_gen (
        .inst_q (inst_out),
        .dec    (dec.imm),
        .imm    (imm)
    );

    operand_mux u_operand_mux (
        .gpr   (gpr),
        .pc_q  (pc_out),
        .imm   (imm),
        .dec   (dec.dp),
        .alu_a (alu_a),
        .alu_b (alu_b)
    );

    assign op       = dec.op;
    assign alu_mode = dec.alu_mode;
    assign wen      = dec.wen;
    assign rd       = dec.rd;

endmodule

// ==== src/if_id_reg.sv ====
// IF/ID pipeline register for valid strobe, pc and instruction
`timescale 1ns/1ps

module if_id_reg import decode_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  valid_in,
    input  xlen_t pc_in,
    input  inst_t inst_in,
    output logic  valid_q,
    output xlen_t pc_q,
    output inst_t inst_q
);

    // no stall path, the stage always advances
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            inst_q  <= '0;
        end else begin
            valid_q <= valid_in;
            pc_q    <= pc_in;
            inst_q  <= inst_in;
        end
    end

endmodule

// ==== src/operand_mux.sv ====
// register read and ALU operand a/b selection
`timescale 1ns/1ps

module operand_mux import decode_pkg::*; (
    input  xlen_t gpr [32],
    input  xlen_t pc_q,
    input  xlen_t imm,
    dec_if.dp     dec,
    output xlen_t alu_a,
    output xlen_t alu_b
);

    xlen_t src1;
    xlen_t src2;

    // gpr comes straight from the register file, read in this cycle
    assign src1 = gpr[dec.rs1];
    assign src2 = gpr[dec.rs2];

    always_comb begin
        case (dec.opa_sel)
            opa_src1:         alu_a = src1;
            opa_src1_lo_zext: alu_a = {32'b0, src1[31:0]};
            opa_src1_lo_high: alu_a = {src1[31:0], 32'b0};  // srlw/sraw shift from the top
            opa_pc:           alu_a = pc_q;
            opa_imm:          alu_a = imm;  // lui
            opa_zero:         alu_a = '0;
            default:          alu_a = '0;
        endcase
    end

    always_comb begin
        case (dec.opb_sel)
            opb_src2:     alu_b = src2;
            opb_src2_lo6: alu_b = {58'b0, src2[5:0]};
            opb_src2_lo5: alu_b = {59'b0, src2[4:0]};
            opb_imm:      alu_b = imm;
            opb_zero:     alu_b = '0;
            default:      alu_b = '0;
        endcase
    end

endmodule

// ==== tb/decode_stage_props.sv ====
// concurrent checks on reset, empty slot and write enable of the decode stage
`timescale 1ns/1ps

module decode_stage_props import decode_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  valid_out,
    input logic  wen,
    input op_t   op,
    input xlen_t alu_a,
    input xlen_t alu_b
);

    assert property (@(posedge clk) rst |=> !valid_out)
        else $error("valid_out high in the cycle after reset");

    // bubble decodes to nothing
    assert property (@(posedge clk) disable iff (rst)
        !valid_out |-> (!wen && alu_a == '0 && alu_b == '0))
        else $error("empty stage with wen or nonzero operands");

    assert property (@(posedge clk) disable iff (rst)
        ((op >= op_beq && op <= op_bgeu) || (op >= op_sb && op <= op_sd)) |-> !wen)
        else $error("wen high for a branch or store");

endmodule

bind decode_stage decode_stage_props u_props (
    .clk       (clk),
    .rst       (rst),
    .valid_out (valid_out),
    .wen       (wen),
    .op        (op),
    .alu_a     (alu_a),
    .alu_b     (alu_b)
);

// ==== tb/tb_decode_stage.sv ====
// decode stage testbench: directed tests, reference model, compare tasks and timeout
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int timeout_cycles = 2000;
    // one hex digit per op in op_t order for funct3 and ALU mode
    localparam string f3_tab   = "0000001456701234560123023467155001234567015500155";
    localparam string mode_tab = "000001111110000000000002376489a018237964089a0189a";

    logic        clk;
    logic        rst;
    xlen_t       gpr [32];
    logic        valid_in;
    xlen_t       pc_in;
    inst_t       inst_in;
    logic        valid_out;
    xlen_t       pc_out;
    inst_t       inst_out;
    xlen_t       alu_a;
    xlen_t       alu_b;
    alu_mode_t   alu_mode;
    reg_idx_t    rd;
    logic        wen;
    op_t         op;
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;

    decode_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int digit(string s, int i);
        byte c;
        c = s[i];
        return (c >= "a") ? c - "a" + 10 : c - "0";
    endfunction

    function automatic logic in_range(op_t o, op_t lo, op_t hi);
        return o >= lo && o <= hi;
    endfunction

    task automatic fill_gpr();
        for (int i = 0; i < 32; i++) begin
            gpr[i] = rand_bits(64);
        end
    endtask

    // RV64I encoding of a kept op over random field bits
    function automatic inst_t encode(op_t o, inst_t r);
        inst_t w;
        w = r;
        case (1'b1)
            o == op_lui:                   w[6:0] = 7'h37;
            o == op_auipc:                 w[6:0] = 7'h17;
            o == op_jal:                   w[6:0] = 7'h6f;
            o == op_jalr:                  w[6:0] = 7'h67;
            in_range(o, op_beq, op_bgeu):  w[6:0] = 7'h63;
            in_range(o, op_lb, op_lwu):    w[6:0] = 7'h03;
            in_range(o, op_sb, op_sd):     w[6:0] = 7'h23;
            in_range(o, op_addi, op_srai): w[6:0] = 7'h13;
            in_range(o, op_add, op_and):   w[6:0] = 7'h33;
            in_range(o, op_addiw, op_sraiw): w[6:0] = 7'h1b;
            default:                       w[6:0] = 7'h3b;
        endcase
        if (o >= op_jalr) begin
            w[14:12] = 3'(digit(f3_tab, o));
        end
        if (in_range(o, op_add, op_and) || in_range(o, op_slliw, op_sraw)) begin
            w[31:25] = (o == op_sub || o == op_sraiw || o == op_subw || o == op_sraw) ? 7'h20 : 7'h00;
        end else if (in_range(o, op_slli, op_srai)) begin
            w[31:26] = (o == op_srai) ? 6'h10 : 6'h00;  // bit 25 stays in shamt
        end
        return w;
    endfunction

    // expected operands, mode and wen
    task automatic model(input op_t o, input inst_t w, input xlen_t pc, output xlen_t ea,
                         output xlen_t eb, output alu_mode_t em, output logic ew);
        xlen_t s1;
        xlen_t s2;
        xlen_t im_u;
        s1 = gpr[w[19:15]];
        s2 = gpr[w[24:20]];
        im_u = {{32{w[31]}}, w[31:12], 12'h000};
        ew = o != op_none && !in_range(o, op_beq, op_bgeu) && !in_range(o, op_sb, op_sd);
        em = alu_mode_t'(digit(mode_tab, o));
        case (o)
            op_none:                    ea = '0;
            op_lui:                     ea = im_u;
            op_auipc, op_jal:           ea = pc;
            op_slliw, op_srliw:         ea = {32'h0, s1[31:0]};
            op_sraiw, op_srlw, op_sraw: ea = {s1[31:0], 32'h0};
            default:                    ea = s1;
        endcase
        case (o)
            op_none, op_lui:              eb = '0;
            op_auipc:                     eb = im_u;
            op_jal:                       eb = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            op_sb, op_sh, op_sw, op_sd:   eb = {{52{w[31]}}, w[31:25], w[11:7]};
            op_slli, op_srli, op_srai:    eb = {58'h0, w[25:20]};
            op_slliw, op_srliw, op_sraiw: eb = {59'h0, w[24:20]};
            op_sll, op_srl:               eb = {58'h0, s2[5:0]};
            op_sllw, op_srlw, op_sraw:    eb = {59'h0, s2[4:0]};
            op_add, op_sub, op_slt, op_sltu, op_xor, op_or, op_and, op_addw, op_subw:
                eb = s2;
            default: eb = in_range(o, op_beq, op_bgeu) ? s2 : {{52{w[31]}}, w[31:20]};
        endcase
    endtask

    task automatic record(logic ok, string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (!ok) begin
            errors++;
            $display("Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_word(string name, xlen_t exp, xlen_t act);
        record(act === exp, name, exp, act);
    endtask

    task automatic check_inst(string name, inst_t exp, inst_t act);
        record(act === exp, name, exp, act);
    endtask

    task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
        record(act === exp, name, exp, act);
    endtask

    task automatic check_mode(string name, alu_mode_t exp, alu_mode_t act);
        record(act === exp, name, exp, act);
    endtask

    task automatic check_op(string name, op_t exp, op_t act);
        record(act === exp, name, exp, act);
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        record(act === exp, name, exp, act);
    endtask

    task automatic check_slot(logic v, op_t o, inst_t w, xlen_t pc);
        xlen_t     ea;
        xlen_t     eb;
        alu_mode_t em;
        logic      ew;
        model(v ? o : op_none, w, pc, ea, eb, em, ew);
        check_bit("valid_out", v, valid_out);
        check_word("pc_out", pc, pc_out);
        check_inst("inst_out", w, inst_out);
        check_op("op", v ? o : op_none, op);
        check_bit("wen", ew, wen);
        check_idx("rd", v ? w[11:7] : 5'd0, rd);
        check_mode("alu_mode", em, alu_mode);
        check_word("alu_a", ea, alu_a);
        check_word("alu_b", eb, alu_b);
    endtask

    // one slot in and its result checked on the next edge
    task automatic run_slot(logic v, op_t o, inst_t w);
        xlen_t pc;
        pc = rand_bits(64) & ~64'h3;
        @(posedge clk);
        #1;
        valid_in = v;
        pc_in = pc;
        inst_in = w;
        @(posedge clk);
        #1;
        valid_in = 1'b0;
        check_slot(v, o, w, pc);
    endtask

    task automatic sweep(op_t lo, op_t hi, int reps);
        op_t o;
        for (int r = 0; r < reps; r++) begin
            for (int k = lo; k <= hi; k++) begin
                o = op_t'(k);
                fill_gpr();
                run_slot(1'b1, o, encode(o, inst_t'(rand_bits(32))));
            end
        end
    endtask

    task automatic test_reset();
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            rst = (i == 0);  // two edges in reset and one out
            check_bit("valid_out", 1'b0, valid_out);
            check_bit("wen", 1'b0, wen);
            check_op("op", op_none, op);
            check_idx("rd", '0, rd);
            check_word("alu_a", '0, alu_a);
            check_word("alu_b", '0, alu_b);
        end
    endtask

    task automatic test_alu_forms();
        sweep(op_addi, op_and, 2);
    endtask

    task automatic test_imm_formats();
        sweep(op_lui, op_sd, 3);
    endtask

    task automatic test_shift_w();
        sweep(op_addiw, op_sraw, 4);
        sweep(op_slli, op_srai, 2);
        sweep(op_sll, op_srl, 2);
    endtask

    task automatic test_bubbles();
        inst_t w;
        fill_gpr();
        for (int i = 0; i < 4; i++) begin
            run_slot(1'b0, op_none, encode(op_add, inst_t'(rand_bits(32))));
        end
        w = inst_t'(rand_bits(32));
        run_slot(1'b1, op_none, {w[31:7], 7'h7f});  // unused major opcode
        run_slot(1'b1, op_none, {7'h01, w[24:15], 3'd0, w[11:7], 7'h33});  // mul
        run_slot(1'b1, op_none, {w[31:15], 3'd2, w[11:7], 7'h63});
    endtask

    task automatic test_stream();
        op_t   prev_o;
        inst_t prev_w;
        xlen_t prev_pc;
        fill_gpr();
        for (int i = 0; i <= 64; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                check_slot(1'b1, prev_o, prev_w, prev_pc);
            end
            prev_o = op_t'(1 + rand_bits(8) % 48);
            prev_w = encode(prev_o, inst_t'(rand_bits(32)));
            prev_pc = rand_bits(64) & ~64'h3;
            valid_in = (i < 64);
            pc_in = prev_pc;
            inst_in = prev_w;
        end
    endtask

    initial begin
        lfsr = 32'hacfb_6a28;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        valid_in = 1'b0;
        pc_in = '0;
        inst_in = '0;
        fill_gpr();
        test_reset();
        test_alu_forms();
        test_imm_formats();
        test_shift_w();
        test_bubbles();
        test_stream();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", timeout_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule
